/* core_ifs.sv */
`timescale 1ns/10ps
`include "cpu_defines.svh"

interface fetch_if;
  import isa_pkg::*;

  logic               valid;
  logic               ready;
  inst_word_u         inst;
  logic [`ADDR_W-1:0] pc;

  modport source (output valid, inst, pc, input ready);
  modport sink   (input valid, inst, pc, output ready);
endinterface

interface dispatch_if;
  logic                  valid;
  logic                  ready;
  logic [2:0]            funct3;
  logic                  alt;
  logic [`REG_W-1:0]     vj;
  logic [`REG_W-1:0]     vk;
  logic [`ROB_TAG_W-1:0] qj;
  logic [`ROB_TAG_W-1:0] qk;
  logic                  j_wait;
  logic                  k_wait;
  logic [`ROB_TAG_W-1:0] dest;

  modport source (output valid, funct3, alt, vj, vk, qj, qk, j_wait, k_wait, dest,
                  input ready);
  modport sink   (input valid, funct3, alt, vj, vk, qj, qk, j_wait, k_wait, dest,
                  output ready);
endinterface

interface operand_if;
  logic [`REG_ID_W-1:0]  rs1_id;
  logic [`REG_ID_W-1:0]  rs2_id;
  logic [`REG_W-1:0]     rs1_val;
  logic [`REG_W-1:0]     rs2_val;
  logic                  rs1_busy;
  logic                  rs2_busy;
  logic [`ROB_TAG_W-1:0] rs1_tag;
  logic [`ROB_TAG_W-1:0] rs2_tag;
  logic [`ROB_TAG_W-1:0] j_tag;    // rob lookup
  logic [`ROB_TAG_W-1:0] k_tag;
  logic                  j_done;
  logic                  k_done;
  logic [`REG_W-1:0]     j_val;
  logic [`REG_W-1:0]     k_val;
  logic                  ren_valid;
  logic [`REG_ID_W-1:0]  ren_rd;
  logic [`ROB_TAG_W-1:0] ren_tag;

  modport requester (output rs1_id, rs2_id, j_tag, k_tag, ren_valid, ren_rd, ren_tag,
                     input rs1_val, rs2_val, rs1_busy, rs2_busy, rs1_tag, rs2_tag,
                     input j_done, k_done, j_val, k_val);
  modport responder (input rs1_id, rs2_id, ren_valid, ren_rd, ren_tag,
                     output rs1_val, rs2_val, rs1_busy, rs2_busy, rs1_tag, rs2_tag);
  modport forwarder (input j_tag, k_tag, output j_done, k_done, j_val, k_val);
endinterface

interface commit_if;
  logic                  valid;
  logic [`REG_ID_W-1:0]  rd;
  logic [`ROB_TAG_W-1:0] tag;
  logic [`REG_W-1:0]     value;

  modport source (output valid, rd, tag, value);
  modport sink   (input valid, rd, tag, value);
endinterface

/* core_pkg.sv */
`include "cpu_defines.svh"

package core_pkg;

  function automatic logic [`REG_W-1:0] alu_eval(
    input logic [2:0]        funct3,
    input logic              alt,
    input logic [`REG_W-1:0] a,
    input logic [`REG_W-1:0] b
  );
    logic [4:0] sh;
    sh = b[4:0];
    case (funct3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << sh;
      3'b010:  return `REG_W'($signed(a) < $signed(b));
      3'b011:  return `REG_W'(a < b);
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> sh;  // sign fill
        return a >> sh;
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // wraps at ROB_DEPTH, not at the tag width
  function automatic logic [`ROB_TAG_W-1:0] tag_next(input logic [`ROB_TAG_W-1:0] tag);
    return (tag == `ROB_TAG_W'(`ROB_DEPTH - 1)) ? '0 : tag + 1'b1;
  endfunction

endpackage

/* cpu.sv */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module cpu (
  input  logic                 clk_in,
  input  logic                 rst_in,
  input  logic                 rdy_in,   // pause when low
  input  logic [7:0]           mem_din,
  output logic [`ADDR_W-1:0]   mem_a,
  output logic                 commit_valid,
  output logic [`REG_ID_W-1:0] commit_rd,
  output logic [`REG_W-1:0]    dbgreg_dout
);

  fetch_if    fetch_bus ();
  dispatch_if disp_bus ();
  operand_if  opnd_bus ();
  commit_if   cmt_bus ();

  // result bus
  logic                  cdb_valid;
  logic [`ROB_TAG_W-1:0] cdb_tag;
  logic [`REG_W-1:0]     cdb_value;

  // rob allocation
  logic                  alloc_valid;
  logic [`REG_ID_W-1:0]  alloc_rd;
  logic [`ROB_TAG_W-1:0] alloc_tag;
  logic                  rob_full;

  inst_fetcher inst_fetcher_0 (
    .clk_in  (clk_in),
    .rst_in  (rst_in),
    .rdy_in  (rdy_in),
    .mem_din (mem_din),
    .mem_a   (mem_a),
    .fetch   (fetch_bus.source)
  );

  issuer issuer_0 (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .fetch       (fetch_bus.sink),
    .dispatch    (disp_bus.source),
    .opnd        (opnd_bus.requester),
    .alloc_valid (alloc_valid),
    .alloc_rd    (alloc_rd),
    .alloc_tag   (alloc_tag),
    .rob_full    (rob_full),
    .cdb_valid   (cdb_valid),
    .cdb_tag     (cdb_tag),
    .cdb_value   (cdb_value)
  );

  reg_file reg_file_0 (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .rdy_in (rdy_in),
    .opnd   (opnd_bus.responder),
    .commit (cmt_bus.sink)
  );

  rs_station rs_station_0 (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .rdy_in    (rdy_in),
    .dispatch  (disp_bus.sink),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_value (cdb_value)
  );

  ro_buffer ro_buffer_0 (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .alloc_valid  (alloc_valid),
    .alloc_rd     (alloc_rd),
    .alloc_tag    (alloc_tag),
    .rob_full     (rob_full),
    .opnd         (opnd_bus.forwarder),
    .cdb_valid    (cdb_valid),
    .cdb_tag      (cdb_tag),
    .cdb_value    (cdb_value),
    .commit       (cmt_bus.source),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .dbgreg_dout  (dbgreg_dout)
  );

endmodule

/* cpu_assert.sv */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module cpu_assert (
  input logic                 clk_in,
  input logic                 rst_in,
  input logic                 rdy_in,
  input logic                 commit_valid,
  input logic [`REG_ID_W-1:0] commit_rd
);

  int fail_count = 0;  // summed into the testbench summary

  pause_blocks_commit: assert property (@(posedge clk_in) !rdy_in |=> !commit_valid)
    else begin
      $error("commit_valid high one cycle after rdy_in low");
      fail_count++;
    end

  reset_clears_commit: assert property (@(posedge clk_in) rst_in |=> !commit_valid)
    else begin
      $error("commit_valid high in the cycle after reset");
      fail_count++;
    end

  // retirement port fully defined outside reset
  commit_known: assert property (@(posedge clk_in) disable iff (rst_in)
                                 !$isunknown({commit_valid, commit_rd}))
    else begin
      $error("commit_valid or commit_rd unknown");
      fail_count++;
    end

endmodule

bind cpu cpu_assert cpu_assert_0 (
  .clk_in       (clk_in),
  .rst_in       (rst_in),
  .rdy_in       (rdy_in),
  .commit_valid (commit_valid),
  .commit_rd    (commit_rd)
);

/* cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data path and register index
`define REG_W      32
`define REG_ID_W   5

// reorder buffer, tag width must cover the depth
`define ROB_DEPTH  4
`define ROB_TAG_W  2

`define RS_DEPTH   2    // station entries

// memory side
`define ADDR_W     32
`define BOOT_ADDR  32'h0000_0000

`endif

/* inst_fetcher.sv */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module inst_fetcher (
  input  logic               clk_in,
  input  logic               rst_in,
  input  logic               rdy_in,
  input  logic [7:0]         mem_din,
  output logic [`ADDR_W-1:0] mem_a,
  fetch_if.source            fetch
);
  import isa_pkg::*;

  logic [`ADDR_W-1:0] pc;
  logic [2:0]         byte_cnt;  // 0..3 issue, 1..4 receive, 5 word ready
  logic [1:0]         offset;
  inst_word_u         word;

  // address stops at pc+3 until the word is taken
  assign offset = (byte_cnt > 3'd3) ? 2'd3 : byte_cnt[1:0];
  assign mem_a  = pc + `ADDR_W'(offset);

  assign fetch.valid = byte_cnt == 3'd5;
  assign fetch.inst  = word;
  assign fetch.pc    = pc;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pc       <= `BOOT_ADDR;
      byte_cnt <= '0;
    end else if (rdy_in) begin
      if (!fetch.valid) begin
        byte_cnt <= byte_cnt + 3'd1;
      end else if (fetch.ready) begin
        pc       <= pc + `ADDR_W'(4);
        byte_cnt <= '0;
      end
    end
  end

  // each byte answers the address of the cycle before, shifted in from the top
  always_ff @(posedge clk_in) begin
    if (rdy_in && byte_cnt != '0 && !fetch.valid) begin
      word <= {mem_din, word[`REG_W-1:8]};
    end
  end

endmodule

/* isa_pkg.sv */
package isa_pkg;

  localparam logic [6:0] OPC_OP     = 7'b0110011;  // register-register
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // register-immediate

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt;

  typedef struct packed {
    logic [11:0] imm;   // also holds the shift amount and the sra bit
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt;

  // low 20 bits line up in both views
  typedef union packed {
    r_fmt r;
    i_fmt i;
  } inst_word_u;

endpackage

/* issuer.sv */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module issuer (
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  logic                  rdy_in,
  fetch_if.sink                 fetch,
  dispatch_if.source            dispatch,
  operand_if.requester          opnd,
  output logic                  alloc_valid,
  output logic [`REG_ID_W-1:0]  alloc_rd,
  input  logic [`ROB_TAG_W-1:0] alloc_tag,
  input  logic                  rob_full,
  input  logic                  cdb_valid,
  input  logic [`ROB_TAG_W-1:0] cdb_tag,
  input  logic [`REG_W-1:0]     cdb_value
);
  import isa_pkg::*;
  import core_pkg::*;

  logic                  is_op;
  logic                  is_imm;
  logic [`REG_ID_W-1:0]  rd;
  logic [`ROB_TAG_W-1:0] next_tag;  // own copy of the rob tail
  logic                  can_issue;
  logic                  accept;
  logic [`REG_W:0]       src_j;     // {wait, value}
  logic [`REG_W:0]       src_k;

  // regfile, then finished rob entry, then the bus this cycle, else wait on tag
  function automatic logic [`REG_W:0] resolve(
    input logic                  busy,
    input logic [`REG_W-1:0]     rf_val,
    input logic                  done,
    input logic [`REG_W-1:0]     rob_val,
    input logic [`ROB_TAG_W-1:0] tag
  );
    if (!busy) return {1'b0, rf_val};
    if (done) return {1'b0, rob_val};
    if (cdb_valid && cdb_tag == tag) return {1'b0, cdb_value};
    return {1'b1, `REG_W'(0)};
  endfunction

  assign is_op  = fetch.inst.r.opcode == OPC_OP;
  assign is_imm = fetch.inst.i.opcode == OPC_OP_IMM;
  assign rd     = (is_op || is_imm) ? fetch.inst.r.rd : '0;  // anything else retires to x0

  assign opnd.rs1_id = (is_op || is_imm) ? fetch.inst.r.rs1 : '0;
  assign opnd.rs2_id = is_op ? fetch.inst.r.rs2 : '0;
  assign opnd.j_tag  = opnd.rs1_tag;
  assign opnd.k_tag  = opnd.rs2_tag;

  always_comb begin
    src_j = resolve(opnd.rs1_busy, opnd.rs1_val, opnd.j_done, opnd.j_val, opnd.rs1_tag);
    if (is_imm) begin
      src_k = {1'b0, `REG_W'($signed(fetch.inst.i.imm))};
    end else begin
      src_k = resolve(opnd.rs2_busy, opnd.rs2_val, opnd.k_done, opnd.k_val, opnd.rs2_tag);
    end
  end

  assign can_issue   = rdy_in && !rob_full;
  assign fetch.ready = can_issue && dispatch.ready;
  assign accept      = fetch.valid && fetch.ready;

  assign dispatch.valid  = fetch.valid && can_issue;
  assign dispatch.funct3 = fetch.inst.r.funct3;
  assign dispatch.alt    = is_op ? fetch.inst.r.funct7[5]
                                 : is_imm && fetch.inst.i.funct3 == 3'b101 && fetch.inst.i.imm[10];
  assign dispatch.vj     = src_j[`REG_W-1:0];
  assign dispatch.j_wait = src_j[`REG_W];
  assign dispatch.qj     = opnd.rs1_tag;
  assign dispatch.vk     = src_k[`REG_W-1:0];
  assign dispatch.k_wait = src_k[`REG_W];
  assign dispatch.qk     = opnd.rs2_tag;
  assign dispatch.dest   = next_tag;

  assign alloc_valid    = accept;
  assign alloc_rd       = rd;
  assign opnd.ren_valid = accept && rd != '0;
  assign opnd.ren_rd    = rd;
  assign opnd.ren_tag   = next_tag;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      next_tag <= '0;
    end else if (accept) begin
      next_tag <= tag_next(next_tag);
    end
  end

endmodule

/* list.f */
+incdir+.
isa_pkg.sv
core_pkg.sv
core_ifs.sv
inst_fetcher.sv
issuer.sv
reg_file.sv
rs_station.sv
ro_buffer.sv
cpu.sv
cpu_assert.sv
tb_cpu.sv

/* reg_file.sv */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module reg_file (
  input  logic         clk_in,
  input  logic         rst_in,
  input  logic         rdy_in,
  operand_if.responder opnd,
  commit_if.sink       commit
);

  logic [`REG_W-1:0]          regs [2**`REG_ID_W];
  logic [2**`REG_ID_W-1:0]    busy;
  logic [`ROB_TAG_W-1:0]      tags [2**`REG_ID_W];  // producing rob entry

  assign opnd.rs1_val  = regs[opnd.rs1_id];
  assign opnd.rs1_busy = busy[opnd.rs1_id];
  assign opnd.rs1_tag  = tags[opnd.rs1_id];
  assign opnd.rs2_val  = regs[opnd.rs2_id];
  assign opnd.rs2_busy = busy[opnd.rs2_id];
  assign opnd.rs2_tag  = tags[opnd.rs2_id];

  // x0 is never written nor renamed, so it stays zero and free
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy <= '0;
      for (int i = 0; i < 2**`REG_ID_W; i++) begin
        regs[i] <= '0;
      end
    end else if (rdy_in) begin
      if (commit.valid && commit.rd != '0) begin
        regs[commit.rd] <= commit.value;
        if (tags[commit.rd] == commit.tag) busy[commit.rd] <= 1'b0;  // no newer writer
      end
      // later assignment wins over a same-cycle commit
      if (opnd.ren_valid && opnd.ren_rd != '0) begin
        busy[opnd.ren_rd] <= 1'b1;
        tags[opnd.ren_rd] <= opnd.ren_tag;
      end
    end
  end

endmodule

/* ro_buffer.sv */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module ro_buffer (
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  logic                  rdy_in,
  input  logic                  alloc_valid,
  input  logic [`REG_ID_W-1:0]  alloc_rd,
  output logic [`ROB_TAG_W-1:0] alloc_tag,
  output logic                  rob_full,
  operand_if.forwarder          opnd,
  input  logic                  cdb_valid,
  input  logic [`ROB_TAG_W-1:0] cdb_tag,
  input  logic [`REG_W-1:0]     cdb_value,
  commit_if.source              commit,
  output logic                  commit_valid,
  output logic [`REG_ID_W-1:0]  commit_rd,
  output logic [`REG_W-1:0]     dbgreg_dout
);
  import core_pkg::*;

  logic [`REG_ID_W-1:0]  rd_q  [`ROB_DEPTH];
  logic [`REG_W-1:0]     val_q [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] done;
  logic [`ROB_TAG_W-1:0] head;
  logic [`ROB_TAG_W-1:0] tail;
  logic [`ROB_TAG_W:0]   count;
  logic                  retire;

  assign rob_full  = count == `ROB_DEPTH;
  assign alloc_tag = tail;
  assign retire    = count != '0 && done[head];

  assign opnd.j_done = done[opnd.j_tag];
  assign opnd.j_val  = val_q[opnd.j_tag];
  assign opnd.k_done = done[opnd.k_tag];
  assign opnd.k_val  = val_q[opnd.k_tag];

  assign commit.valid = retire && rdy_in;
  assign commit.rd    = rd_q[head];
  assign commit.tag   = head;
  assign commit.value = val_q[head];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      head         <= '0;
      tail         <= '0;
      count        <= '0;
      done         <= '0;
      commit_valid <= 1'b0;
      commit_rd    <= '0;
      dbgreg_dout  <= '0;
    end else begin
      commit_valid <= retire && rdy_in;  // drops during a pause
      if (rdy_in) begin
        if (alloc_valid) begin
          rd_q[tail] <= alloc_rd;
          done[tail] <= 1'b0;
          tail       <= tag_next(tail);
        end
        if (cdb_valid) begin
          done[cdb_tag]  <= 1'b1;
          val_q[cdb_tag] <= cdb_value;
        end
        if (retire) begin
          commit_rd   <= rd_q[head];
          dbgreg_dout <= val_q[head];
          head        <= tag_next(head);
        end
        if (alloc_valid && !retire) count <= count + 1'b1;
        else if (!alloc_valid && retire) count <= count - 1'b1;
      end
    end
  end

endmodule

/* rs_station.sv */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module rs_station (
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  logic                  rdy_in,
  dispatch_if.sink              dispatch,
  output logic                  cdb_valid,
  output logic [`ROB_TAG_W-1:0] cdb_tag,
  output logic [`REG_W-1:0]     cdb_value
);
  import core_pkg::*;

  logic [`RS_DEPTH-1:0]  busy;
  logic [`RS_DEPTH-1:0]  j_wait;
  logic [`RS_DEPTH-1:0]  k_wait;
  logic [`RS_DEPTH-1:0]  alt;
  logic [2:0]            funct3 [`RS_DEPTH];
  logic [`REG_W-1:0]     vj     [`RS_DEPTH];
  logic [`REG_W-1:0]     vk     [`RS_DEPTH];
  logic [`ROB_TAG_W-1:0] qj     [`RS_DEPTH];
  logic [`ROB_TAG_W-1:0] qk     [`RS_DEPTH];
  logic [`ROB_TAG_W-1:0] dest   [`RS_DEPTH];
  logic [`RS_DEPTH-1:0]  older  [`RS_DEPTH];  // older[i][j] set if j came in before i
  logic [`RS_DEPTH-1:0]  ready_v;
  logic                  ex_hit;
  int                    ex_idx;
  int                    free_idx;

  assign ready_v        = busy & ~j_wait & ~k_wait;
  assign dispatch.ready = ~&busy;

  // pick the ready entry with no older ready one, and the lowest free slot
  always_comb begin
    ex_hit   = 1'b0;
    ex_idx   = 0;
    free_idx = 0;
    for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
      if (ready_v[i] && (older[i] & ready_v) == '0) begin
        ex_hit = 1'b1;
        ex_idx = i;
      end
      if (!busy[i]) free_idx = i;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy      <= '0;
      cdb_valid <= 1'b0;
    end else if (rdy_in) begin
      cdb_valid <= ex_hit;
      if (ex_hit) begin
        cdb_tag      <= dest[ex_idx];
        cdb_value    <= alu_eval(funct3[ex_idx], alt[ex_idx], vj[ex_idx], vk[ex_idx]);
        busy[ex_idx] <= 1'b0;
      end
      // snoop the bus, our own last result included
      for (int i = 0; i < `RS_DEPTH; i++) begin
        if (cdb_valid && j_wait[i] && qj[i] == cdb_tag) begin
          vj[i]     <= cdb_value;
          j_wait[i] <= 1'b0;
        end
        if (cdb_valid && k_wait[i] && qk[i] == cdb_tag) begin
          vk[i]     <= cdb_value;
          k_wait[i] <= 1'b0;
        end
        if (dispatch.valid && dispatch.ready) older[i][free_idx] <= 1'b0;
      end
      if (dispatch.valid && dispatch.ready) begin
        busy[free_idx]   <= 1'b1;
        older[free_idx]  <= busy;
        funct3[free_idx] <= dispatch.funct3;
        alt[free_idx]    <= dispatch.alt;
        vj[free_idx]     <= dispatch.vj;
        vk[free_idx]     <= dispatch.vk;
        qj[free_idx]     <= dispatch.qj;
        qk[free_idx]     <= dispatch.qk;
        j_wait[free_idx] <= dispatch.j_wait;
        k_wait[free_idx] <= dispatch.k_wait;
        dest[free_idx]   <= dispatch.dest;
      end
    end
  end

endmodule

/* tb_cpu.sv */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module tb_cpu;

  localparam int         TIMEOUT = 200;  // cycles allowed per retirement
  localparam logic [6:0] OP      = 7'b0110011;
  localparam logic [6:0] OP_IMM  = 7'b0010011;
  localparam logic [2:0] F3_ADD  = 3'd0;
  localparam logic [2:0] F3_SLL  = 3'd1;
  localparam logic [2:0] F3_SLT  = 3'd2;
  localparam logic [2:0] F3_SLTU = 3'd3;
  localparam logic [2:0] F3_XOR  = 3'd4;
  localparam logic [2:0] F3_SR   = 3'd5;
  localparam logic [2:0] F3_OR   = 3'd6;
  localparam logic [2:0] F3_AND  = 3'd7;

  logic                 clk_in;
  logic                 rst_in;
  logic                 rdy_in;
  logic [7:0]           mem_din;
  logic [`ADDR_W-1:0]   mem_a;
  logic                 commit_valid;
  logic [`REG_ID_W-1:0] commit_rd;
  logic [`REG_W-1:0]    dbgreg_dout;

  logic [7:0]           mem [1024];
  logic [`ADDR_W-1:0]   mem_addr_q;
  logic [31:0]          prog [$];
  logic [`REG_ID_W-1:0] exp_rd [$];
  logic [`REG_W-1:0]    exp_val [$];
  logic [31:0]          lfsr_state;
  int                   errors;
  int                   checks;
  int                   tests_run;
  int                   total;
  bit                   timed_out;

  cpu uut (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .mem_din      (mem_din),
    .mem_a        (mem_a),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .dbgreg_dout  (dbgreg_dout)
  );

  always #4 clk_in = ~clk_in;

  // byte memory, one cycle latency, frozen together with the core
  always @(posedge clk_in) begin
    if (rdy_in) mem_addr_q <= mem_a;
  end

  always @(negedge clk_in) begin
    mem_din <= mem[mem_addr_q[9:0]];
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic [31:0] encode_r(input logic [2:0] f3, input logic alt,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic logic [31:0] encode_i(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OP_IMM};
  endfunction

  // result of one OP or OP-IMM word as the ISA defines it
  function automatic logic [31:0] isa_exec(input logic [31:0] w, input logic [31:0] a,
                                           input logic [31:0] rs2v);
    logic [31:0]        b;
    logic signed [31:0] sa;
    logic               imm_form;
    imm_form = w[6:0] == OP_IMM;
    b        = imm_form ? {{20{w[31]}}, w[31:20]} : rs2v;
    sa       = a;
    case (w[14:12])
      F3_ADD:  return (!imm_form && w[30]) ? a - b : a + b;
      F3_SLL:  return a << b[4:0];
      F3_SLT:  return {31'd0, $signed(a) < $signed(b)};
      F3_SLTU: return {31'd0, a < b};
      F3_XOR:  return a ^ b;
      F3_SR: begin
        if (w[30]) return sa >>> b[4:0];  // srai keeps the sign
        return a >> b[4:0];
      end
      F3_OR:   return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic run_reference();
    logic [31:0] regs [32];
    logic [31:0] w;
    logic [31:0] v;
    logic        alu_op;
    exp_rd.delete();
    exp_val.delete();
    foreach (regs[r]) regs[r] = '0;
    foreach (prog[i]) begin
      w      = prog[i];
      alu_op = w[6:0] == OP || w[6:0] == OP_IMM;
      v      = alu_op ? isa_exec(w, regs[w[19:15]], regs[w[24:20]]) : '0;
      exp_rd.push_back(alu_op ? w[11:7] : 5'd0);  // other opcodes retire to x0
      exp_val.push_back(v);
      if (alu_op && w[11:7] != 5'd0) regs[w[11:7]] = v;
    end
  endtask

  task automatic restart_core();
    int base;
    @(negedge clk_in);
    rst_in    = 1'b1;
    rdy_in    = 1'b1;
    timed_out = 1'b0;
    base      = `BOOT_ADDR;
    foreach (mem[a]) mem[a] = 8'h00;
    foreach (prog[i]) begin
      for (int b = 0; b < 4; b++) begin
        mem[base + 4 * i + b] = prog[i][8 * b +: 8];  // little-endian
      end
    end
    run_reference();
    repeat (5) @(negedge clk_in);
    rst_in = 1'b0;
  endtask

  task automatic check_rd(input logic [`REG_ID_W-1:0] expected,
                          input logic [`REG_ID_W-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED commit_rd expected 0x%h actual 0x%h at %0t",
               expected, actual, $time);
    end
  endtask

  task automatic check_value(input logic [`REG_W-1:0] expected,
                             input logic [`REG_W-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED dbgreg_dout expected 0x%h actual 0x%h at %0t",
               expected, actual, $time);
    end
  endtask

  task automatic check_addr(input logic [`ADDR_W-1:0] expected,
                            input logic [`ADDR_W-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED mem_a expected 0x%h actual 0x%h at %0t",
               expected, actual, $time);
    end
  endtask

  // compare retirements first..last-1 against the reference
  task automatic expect_commits(input int first, input int last);
    bit seen;
    for (int k = first; k < last && !timed_out; k++) begin
      seen = 1'b0;
      for (int n = 0; n < TIMEOUT && !seen; n++) begin
        @(negedge clk_in);
        seen = commit_valid;
      end
      if (!seen) begin
        errors++;
        timed_out = 1'b1;
        $display("no retirement arrived for instruction %0d within %0d cycles", k, TIMEOUT);
      end else begin
        check_rd(exp_rd[k], commit_rd);
        check_value(exp_val[k], dbgreg_dout);
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) $display("test %-20s ok", name);
    else $display("test %-20s %0d errors", name, errors - errs_before);
  endtask

  task automatic reset_behavior();
    int errs;
    errs = errors;
    prog.delete();
    prog.push_back(encode_i(F3_ADD, 5'd1, 5'd0, 12'h123));
    prog.push_back(encode_i(F3_XOR, 5'd2, 5'd1, 12'hfff));
    restart_core();
    for (int k = 0; k < 4; k++) begin
      if (k > 0) @(negedge clk_in);
      check_addr(`BOOT_ADDR + k, mem_a);
      if (commit_valid) begin
        errors++;
        $display("retirement seen before the first word was fetched");
      end
    end
    expect_commits(0, exp_rd.size());
    report_test("reset", errs);
  endtask

  task automatic dependent_chain();
    int errs;
    errs = errors;
    prog.delete();
    prog.push_back(encode_i(F3_ADD, 5'd1, 5'd0, 12'd5));
    prog.push_back(encode_i(F3_ADD, 5'd2, 5'd1, 12'hffd));
    prog.push_back(encode_r(F3_ADD, 1'b0, 5'd3, 5'd2, 5'd1));
    prog.push_back(encode_r(F3_ADD, 1'b1, 5'd4, 5'd3, 5'd2));  // sub
    prog.push_back(encode_i(F3_ADD, 5'd4, 5'd4, 12'd100));
    prog.push_back(encode_r(F3_ADD, 1'b0, 5'd5, 5'd4, 5'd4));
    prog.push_back(encode_r(F3_ADD, 1'b1, 5'd6, 5'd0, 5'd5));
    restart_core();
    expect_commits(0, exp_rd.size());
    report_test("dependent_chain", errs);
  endtask

  task automatic all_alu_ops();
    int          errs;
    logic [11:0] imm;
    errs = errors;
    prog.delete();
    // wide random values in x1 and x2
    for (int r = 1; r <= 2; r++) begin
      prog.push_back(encode_i(F3_ADD, 5'(r), 5'd0, 12'(rand_bits(12))));
      prog.push_back(encode_i(F3_SLL, 5'(r), 5'(r), 12'(rand_bits(5))));
      prog.push_back(encode_i(F3_XOR, 5'(r), 5'(r), 12'(rand_bits(12))));
    end
    prog.push_back(encode_r(F3_ADD, 1'b1, 5'd3, 5'd0, 5'd2));  // x3 = -x2
    for (int f = 0; f < 8; f++) begin
      prog.push_back(encode_r(3'(f), 1'b0, 5'(10 + f), 5'd1, 5'd2));
    end
    prog.push_back(encode_r(F3_ADD, 1'b1, 5'd18, 5'd1, 5'd2));
    prog.push_back(encode_r(F3_SR, 1'b1, 5'd19, 5'd3, 5'd1));
    prog.push_back(encode_r(F3_SLT, 1'b0, 5'd20, 5'd1, 5'd3));
    prog.push_back(encode_r(F3_SLTU, 1'b0, 5'd21, 5'd1, 5'd3));
    for (int f = 0; f < 8; f++) begin
      if (f == 1 || f == 5) imm = 12'(rand_bits(5));  // shift amounts
      else imm = 12'(rand_bits(12));
      prog.push_back(encode_i(3'(f), 5'(22 + f), (f % 2) ? 5'd1 : 5'd3, imm));
    end
    prog.push_back(encode_i(F3_SR, 5'd30, 5'd3, {7'b0100000, 5'(rand_bits(5))}));
    prog.push_back(encode_i(F3_SR, 5'd31, 5'd1, {7'b0100000, 5'(rand_bits(5))}));
    restart_core();
    expect_commits(0, exp_rd.size());
    report_test("all_alu_ops", errs);
  endtask

  task automatic pause_resume();
    int                 errs;
    logic [`ADDR_W-1:0] held_a;
    errs = errors;
    prog.delete();
    prog.push_back(encode_i(F3_ADD, 5'd1, 5'd0, 12'd11));
    prog.push_back(encode_i(F3_ADD, 5'd2, 5'd0, 12'hffb));
    prog.push_back(encode_r(F3_ADD, 1'b0, 5'd3, 5'd1, 5'd2));
    prog.push_back(encode_r(F3_SLL, 1'b0, 5'd4, 5'd3, 5'd1));
    prog.push_back(encode_r(F3_ADD, 1'b1, 5'd5, 5'd4, 5'd1));
    prog.push_back(encode_i(F3_XOR, 5'd6, 5'd5, 12'h5a5));
    prog.push_back(encode_r(F3_AND, 1'b0, 5'd7, 5'd6, 5'd4));
    prog.push_back(encode_r(F3_OR, 1'b0, 5'd8, 5'd7, 5'd2));
    restart_core();
    expect_commits(0, 3);
    held_a = mem_a;
    rdy_in = 1'b0;
    repeat (10) begin
      @(negedge clk_in);
      check_addr(held_a, mem_a);
      if (commit_valid) begin
        errors++;
        $display("retirement seen while rdy_in was low at %0t", $time);
      end
    end
    rdy_in = 1'b1;
    expect_commits(3, exp_rd.size());
    report_test("pause", errs);
  endtask

  task automatic x0_and_unsupported();
    int errs;
    errs = errors;
    prog.delete();
    prog.push_back(encode_i(F3_ADD, 5'd0, 5'd0, 12'd123));
    prog.push_back(encode_i(F3_ADD, 5'd1, 5'd0, 12'd7));
    prog.push_back(encode_r(F3_ADD, 1'b0, 5'd0, 5'd1, 5'd1));
    prog.push_back(32'h0000_0073);  // ecall
    prog.push_back(32'h0041_2183);  // lw x3, 4(x2)
    prog.push_back(encode_r(F3_ADD, 1'b0, 5'd4, 5'd0, 5'd1));
    prog.push_back(encode_r(F3_OR, 1'b0, 5'd5, 5'd3, 5'd0));
    prog.push_back(encode_i(F3_ADD, 5'd6, 5'd3, 12'd1));
    prog.push_back(encode_i(F3_ADD, 5'd7, 5'd0, 12'h800));
    restart_core();
    expect_commits(0, exp_rd.size());
    report_test("x0_unsupported", errs);
  endtask

  // more in flight than the rob holds
  task automatic rob_backpressure();
    int errs;
    errs = errors;
    prog.delete();
    for (int r = 1; r <= 4; r++) begin
      prog.push_back(encode_i(F3_ADD, 5'(r), 5'd0, 12'(r)));
    end
    prog.push_back(encode_r(F3_ADD, 1'b0, 5'd5, 5'd1, 5'd2));
    prog.push_back(encode_r(F3_ADD, 1'b0, 5'd6, 5'd5, 5'd3));
    prog.push_back(encode_r(F3_ADD, 1'b0, 5'd7, 5'd6, 5'd4));
    prog.push_back(encode_r(F3_ADD, 1'b1, 5'd8, 5'd7, 5'd1));
    prog.push_back(encode_i(F3_ADD, 5'd9, 5'd8, 12'hff9));
    prog.push_back(encode_r(F3_XOR, 1'b0, 5'd10, 5'd9, 5'd5));
    prog.push_back(encode_r(F3_OR, 1'b0, 5'd11, 5'd10, 5'd2));
    prog.push_back(encode_r(F3_AND, 1'b0, 5'd12, 5'd11, 5'd7));
    restart_core();
    expect_commits(0, exp_rd.size());
    report_test("backpressure", errs);
  endtask

  initial begin
    clk_in     = 1'b0;
    rst_in     = 1'b1;
    rdy_in     = 1'b1;
    mem_din    = 8'h00;
    mem_addr_q = '0;
    lfsr_state = 32'h2649f815;
    errors     = 0;
    checks     = 0;
    tests_run  = 0;
    timed_out  = 1'b0;
    reset_behavior();
    dependent_chain();
    all_alu_ops();
    pause_resume();
    x0_and_unsupported();
    rob_backpressure();
    total = errors + uut.cpu_assert_0.fail_count;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests_run, checks, errors, uut.cpu_assert_0.fail_count);
    if (total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
